//--- Bender.yml
package:
  name: pwconv

sources:
  - files:
      - verilog/pwconvPkg.sv
      - verilog/streamSkid.sv
      - verilog/dspCascade.sv
      - verilog/pointwiseConvolve.sv
      - verilog/convConfigRegs.sv
      - verilog/pwconvTop.sv
  - target: test
    files:
      - verif/pwconvTb.sv

//--- tb.f
verilog/pwconvPkg.sv
verilog/streamSkid.sv
verilog/dspCascade.sv
verilog/pointwiseConvolve.sv
verilog/convConfigRegs.sv
verilog/pwconvTop.sv
verif/pwconvTb.sv

//--- verif/pwconvGolden.txt
# W addr wstrb data, R addr expected data, X unmapped addr; these fields are hex.
# V activations a0..a7 then expected results r0..r3, all signed decimal.
W 00 f 01010101
W 04 f 01010101
W 08 f 11223344
W 08 5 00fe0002
R 08 11fe3302
W 08 a 0300ff00
W 10 f 00000004
W 14 f fc000000
W 1c f 7f7f7f7f
W 20 f 00000001
R 00 01010101
R 04 01010101
R 08 03feff02
R 0c 00000000
R 10 00000004
R 14 fc000000
R 18 00000000
R 1c 7f7f7f7f
R 20 00000001
X 24
X 02
X fc
R 08 03feff02
R 1c 7f7f7f7f
R 20 00000001
V 1 2 3 4 5 6 7 8 18 3 -14 127
V -1 -2 -3 -4 0 0 0 0 -5 -3 -2 0
V 10 -10 20 -20 0 0 0 1 0 -35 18 63
V 0 0 0 0 0 0 0 -1 -1 0 2 -64
R 20 00000001
V 1 2 3 4 5 6 7 8 18 3 -14 127
V -1 -2 -3 -4 0 0 0 0 -5 -3 -2 0
V 10 -10 20 -20 0 0 0 1 0 -35 18 63
V 0 0 0 0 0 0 0 -1 -1 0 2 -64
W 20 f 00000003
R 20 00000003
V 127 127 127 127 127 127 127 127 127 31 0 127
V -128 -128 -128 -128 -128 -128 -128 -128 -128 -32 0 -128
V -128 127 -128 127 0 0 0 0 -1 31 -64 0
V 100 0 0 0 0 0 0 -100 0 25 100 -128
V 3 0 0 0 0 0 0 0 0 0 1 0
V 0 0 0 0 -1 0 0 0 -1 0 0 -16

//--- verif/pwconvTb.sv
`timescale 1ns/10ps

module pwconvTb;

    localparam int TimeoutCycles = 200;

    bit                               clock = 1'b0;
    bit                               arstN = 1'b0;
    bit [pwconvPkg::AxiAddrWidth-1:0] awaddr = '0;
    bit                               awvalid = 1'b0;
    bit                               awready;
    bit [pwconvPkg::AxiDataWidth-1:0] wdata = '0;
    bit [pwconvPkg::AxiStrbWidth-1:0] wstrb = '0;
    bit                               wvalid = 1'b0;
    bit                               wready;
    bit [1:0]                         bresp;
    bit                               bvalid;
    bit                               bready = 1'b0;
    bit [pwconvPkg::AxiAddrWidth-1:0] araddr = '0;
    bit                               arvalid = 1'b0;
    bit                               arready;
    bit [pwconvPkg::AxiDataWidth-1:0] rdata;
    bit [1:0]                         rresp;
    bit                               rvalid;
    bit                               rready = 1'b0;
    bit                               slaveValid = 1'b0;
    bit                               slaveReady;
    pwconvPkg::activationVec_t        slaveData = '0;
    bit                               masterValid;
    bit                               masterReady = 1'b0;
    pwconvPkg::resultVec_t            masterData;

    bit [31:0] rngState = 32'habd5c34b;
    int        errorCount = 0;
    int        testsRun = 0;
    int        testsFailed = 0;
    pwconvPkg::activationVec_t pixelQueue[$];
    pwconvPkg::resultVec_t     expectQueue[$];

    always #4 clock = ~clock;

    pwconvTop pwconvTop_i (
        .clock_i      (clock),
        .arstN_i      (arstN),
        .awaddr_i     (awaddr),
        .awvalid_i    (awvalid),
        .awready_o    (awready),
        .wdata_i      (wdata),
        .wstrb_i      (wstrb),
        .wvalid_i     (wvalid),
        .wready_o     (wready),
        .bresp_o      (bresp),
        .bvalid_o     (bvalid),
        .bready_i     (bready),
        .araddr_i     (araddr),
        .arvalid_i    (arvalid),
        .arready_o    (arready),
        .rdata_o      (rdata),
        .rresp_o      (rresp),
        .rvalid_o     (rvalid),
        .rready_i     (rready),
        .slaveValid_i (slaveValid),
        .slaveReady_o (slaveReady),
        .slaveData_i  (slaveData),
        .masterValid_o(masterValid),
        .masterReady_i(masterReady),
        .masterData_o (masterData)
    );

    function automatic bit [31:0] xorshift(input bit [31:0] state);
        bit [31:0] x;
        x = state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    task automatic checkValue(input string name, input bit [31:0] expected,
                              input bit [31:0] actual);
        assert (actual == expected) else begin
            $display("** Error at time %0t: %s expected %h, got %h", $time, name, expected, actual);
            errorCount++;
        end
    endtask

    task automatic reportTimeout(input string what);
        $display("Timeout at time %0t: no %s within %0d cycles.", $time, what, TimeoutCycles);
        errorCount++;
    endtask

    task automatic finishTest(input string name, input int failures);
        testsRun++;
        if (failures == 0) begin
            $display("test %s: ok", name);
        end else begin
            testsFailed++;
            $display("test %s: failed with %0d errors", name, failures);
        end
    endtask

    // every task starts and ends just after a rising edge.
    task automatic writeReg(input bit [pwconvPkg::AxiAddrWidth-1:0] addr,
                            input bit [pwconvPkg::AxiStrbWidth-1:0] strb,
                            input bit [pwconvPkg::AxiDataWidth-1:0] data,
                            output bit [1:0] resp);
        int cycles;
        bit done;
        awaddr  <= addr;
        awvalid <= 1'b1;
        wdata   <= data;
        wstrb   <= strb;
        wvalid  <= 1'b1;
        cycles = 0;
        done = 1'b0;
        while (!done && cycles < TimeoutCycles) begin
            @(posedge clock);
            cycles++;
            done = awready && wready;
        end
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        if (!done) begin
            reportTimeout("write address handshake");
        end
        cycles = 0;
        done = 1'b0;
        while (!done && cycles < TimeoutCycles) begin
            @(posedge clock);
            cycles++;
            done = bvalid;
        end
        resp = bresp;
        if (!done) begin
            reportTimeout("write response");
        end else begin
            bready <= 1'b1; // the slave must hold bvalid while bready is still low.
            @(posedge clock);
            checkValue("bvalid_o", 1, bvalid);
            bready <= 1'b0;
        end
    endtask

    task automatic readReg(input bit [pwconvPkg::AxiAddrWidth-1:0] addr,
                           output bit [pwconvPkg::AxiDataWidth-1:0] data,
                           output bit [1:0] resp);
        int cycles;
        bit done;
        araddr  <= addr;
        arvalid <= 1'b1;
        cycles = 0;
        done = 1'b0;
        while (!done && cycles < TimeoutCycles) begin
            @(posedge clock);
            cycles++;
            done = arready;
        end
        arvalid <= 1'b0;
        if (!done) begin
            reportTimeout("read address handshake");
        end
        cycles = 0;
        done = 1'b0;
        while (!done && cycles < TimeoutCycles) begin
            @(posedge clock);
            cycles++;
            done = rvalid;
        end
        data = rdata;
        resp = rresp;
        if (!done) begin
            reportTimeout("read data");
        end else begin
            rready <= 1'b1; // the slave must hold rvalid while rready is still low.
            @(posedge clock);
            checkValue("rvalid_o", 1, rvalid);
            rready <= 1'b0;
        end
    endtask

    task automatic drivePixels();
        int cycles;
        bit taken;
        for (int n = 0; n < pixelQueue.size(); n++) begin
            slaveValid <= 1'b1;
            slaveData  <= pixelQueue[n];
            cycles = 0;
            taken = 1'b0;
            while (!taken && cycles < TimeoutCycles) begin
                @(posedge clock);
                cycles++;
                taken = slaveReady;
            end
            if (!taken) begin
                reportTimeout("pixel accepted on slaveReady_o");
                break;
            end
        end
        slaveValid <= 1'b0;
    endtask

    task automatic collectResults(input bit randomReady, input int expectedCount,
                                  output int received);
        int idle;
        pwconvPkg::resultVec_t expected;
        received = 0;
        idle = 0;
        if (randomReady) begin
            rngState = xorshift(rngState);
            masterReady <= rngState[0];
        end else begin
            masterReady <= 1'b1;
        end
        while (received < expectedCount && idle < TimeoutCycles) begin
            @(posedge clock);
            idle++;
            if (masterValid && masterReady) begin
                expected = expectQueue.pop_front();
                checkValue("masterData_o", expected, masterData);
                received++;
                idle = 0;
            end
            if (randomReady) begin
                rngState = xorshift(rngState);
                masterReady <= rngState[0]; // about half the cycles stall the output.
            end
        end
        masterReady <= 1'b1;
        if (received < expectedCount) begin
            reportTimeout("result on masterData_o");
        end
    endtask

    task automatic runBatch(input bit randomReady, input string name);
        int received;
        int errorsBefore;
        int count;
        errorsBefore = errorCount;
        count = pixelQueue.size();
        fork
            drivePixels();
            collectResults(randomReady, count, received);
        join
        checkValue("result count", count, received);
        // the pipeline is empty now, so any further beat is a duplicate.
        for (int c = 0; c < pwconvPkg::CascadeLatency + 4; c++) begin
            @(posedge clock);
            assert (!masterValid) else begin
                $display("Unexpected extra result on masterData_o at time %0t.", $time);
                errorCount++;
            end
        end
        pixelQueue.delete();
        expectQueue.delete();
        finishTest(name, errorCount - errorsBefore);
    endtask

    initial begin
        int fd;
        string line;
        string batchName;
        byte kind;
        bit [pwconvPkg::AxiAddrWidth-1:0] addr;
        bit [pwconvPkg::AxiStrbWidth-1:0] strb;
        bit [pwconvPkg::AxiDataWidth-1:0] data;
        bit [pwconvPkg::AxiDataWidth-1:0] expected;
        bit [pwconvPkg::AxiDataWidth-1:0] readData;
        bit [1:0] resp;
        int values[12];
        int errorsBefore;
        int registerErrors;
        int badAddrErrors;
        int batches;
        pwconvPkg::activationVec_t pixel;
        pwconvPkg::resultVec_t result;

        registerErrors = 0;
        badAddrErrors = 0;
        batches = 0;
        repeat (10) @(posedge clock);
        arstN <= 1'b1;
        @(posedge clock);

        errorsBefore = errorCount;
        checkValue("masterValid_o", 0, masterValid);
        checkValue("bvalid_o", 0, bvalid);
        checkValue("rvalid_o", 0, rvalid);
        checkValue("awready_o", 0, awready);
        checkValue("wready_o", 0, wready);
        checkValue("arready_o", 0, arready);
        @(posedge clock);
        checkValue("slaveReady_o", 1, slaveReady);
        for (int w = 0; w <= pwconvPkg::WeightWords; w++) begin
            addr = (w == pwconvPkg::WeightWords) ? pwconvPkg::ShiftAddr
                                                 : pwconvPkg::WeightBase + 8'(w * 4);
            readReg(addr, readData, resp);
            checkValue("rdata_o", 0, readData);
            checkValue("rresp_o", pwconvPkg::RespOkay, resp);
        end
        finishTest("reset state", errorCount - errorsBefore);

        fd = $fopen("verif/pwconvGolden.txt", "r");
        if (fd == 0) begin
            $display("Could not open verif/pwconvGolden.txt for reading.");
            errorCount++;
        end else begin
            while ($fgets(line, fd)) begin
                kind = line.getc(0);
                if (kind != "V" && pixelQueue.size() != 0) begin
                    batchName = (batches == 0) ? "convolution"
                                               : $sformatf("back-pressure batch %0d", batches);
                    runBatch(batches != 0, batchName);
                    batches++;
                end
                errorsBefore = errorCount;
                case (kind)
                    "W": begin
                        void'($sscanf(line, "W %h %h %h", addr, strb, data));
                        writeReg(addr, strb, data, resp);
                        checkValue("bresp_o", pwconvPkg::RespOkay, resp);
                        registerErrors += errorCount - errorsBefore;
                    end
                    "R": begin
                        void'($sscanf(line, "R %h %h", addr, expected));
                        readReg(addr, readData, resp);
                        checkValue("rdata_o", expected, readData);
                        checkValue("rresp_o", pwconvPkg::RespOkay, resp);
                        registerErrors += errorCount - errorsBefore;
                    end
                    "X": begin
                        void'($sscanf(line, "X %h", addr));
                        writeReg(addr, 4'hf, 32'hffffffff, resp);
                        checkValue("bresp_o", pwconvPkg::RespSlvErr, resp);
                        readReg(addr, readData, resp);
                        checkValue("rresp_o", pwconvPkg::RespSlvErr, resp);
                        checkValue("rdata_o", 0, readData);
                        badAddrErrors += errorCount - errorsBefore;
                    end
                    "V": begin
                        void'($sscanf(line, "V %d %d %d %d %d %d %d %d %d %d %d %d",
                                      values[0], values[1], values[2], values[3],
                                      values[4], values[5], values[6], values[7],
                                      values[8], values[9], values[10], values[11]));
                        for (int c = 0; c < pwconvPkg::InChannels; c++) begin
                            pixel[c] = values[c][7:0];
                        end
                        for (int c = 0; c < pwconvPkg::OutChannels; c++) begin
                            result[c] = values[pwconvPkg::InChannels + c][7:0];
                        end
                        pixelQueue.push_back(pixel);
                        expectQueue.push_back(result);
                    end
                    default: begin
                    end
                endcase
            end
            if (pixelQueue.size() != 0) begin
                runBatch(batches != 0, $sformatf("back-pressure batch %0d", batches));
            end
            $fclose(fd);
        end
        finishTest("register access", registerErrors);
        finishTest("bad address", badAddrErrors);

        $display("tests run %0d, tests failed %0d, checks failed %0d",
                 testsRun, testsFailed, errorCount);
        if (errorCount == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule : pwconvTb

//--- verilog/convConfigRegs.sv
`timescale 1ns/10ps

module convConfigRegs (
    input  bit                               clock_i,
    input  bit                               arstN_i,

    input  bit [pwconvPkg::AxiAddrWidth-1:0] awaddr_i,
    input  bit                               awvalid_i,
    output bit                               awready_o,

    input  bit [pwconvPkg::AxiDataWidth-1:0] wdata_i,
    input  bit [pwconvPkg::AxiStrbWidth-1:0] wstrb_i,
    input  bit                               wvalid_i,
    output bit                               wready_o,

    output bit [1:0]                         bresp_o,
    output bit                               bvalid_o,
    input  bit                               bready_i,

    input  bit [pwconvPkg::AxiAddrWidth-1:0] araddr_i,
    input  bit                               arvalid_i,
    output bit                               arready_o,

    output bit [pwconvPkg::AxiDataWidth-1:0] rdata_o,
    output bit [1:0]                         rresp_o,
    output bit                               rvalid_o,
    input  bit                               rready_i,

    output pwconvPkg::weightMatrix_t         weights_o,
    output bit [pwconvPkg::ShiftWidth-1:0]   shift_o
);

    bit writeAccept;
    bit writeFire;
    bit writeWeight;
    bit writeShift;
    int writeWord;
    bit readAccept;
    bit readFire;
    bit readWeight;
    bit readShift;
    int readWord;
    bit [pwconvPkg::AxiDataWidth-1:0] readValue;

    function automatic bit isWeightAddr(input bit [pwconvPkg::AxiAddrWidth-1:0] addr);
        bit [pwconvPkg::AxiAddrWidth-1:0] offset;
        offset = addr - pwconvPkg::WeightBase; // wraps high for addresses below the base.
        return offset < pwconvPkg::AxiAddrWidth'(pwconvPkg::WeightWords * pwconvPkg::AxiStrbWidth)
            && offset[1:0] == 2'b00;
    endfunction

    function automatic int wordIndex(input bit [pwconvPkg::AxiAddrWidth-1:0] addr);
        bit [pwconvPkg::AxiAddrWidth-1:0] offset;
        offset = addr - pwconvPkg::WeightBase;
        return int'(offset[pwconvPkg::AxiAddrWidth-1:2]);
    endfunction

    assign awready_o   = writeAccept;
    assign wready_o    = writeAccept; // address and data are taken together.
    assign writeFire   = writeAccept && awvalid_i && wvalid_i;
    assign writeWeight = isWeightAddr(awaddr_i);
    assign writeShift  = awaddr_i == pwconvPkg::ShiftAddr;
    assign writeWord   = wordIndex(awaddr_i);

    assign arready_o  = readAccept;
    assign readFire   = readAccept && arvalid_i;
    assign readWeight = isWeightAddr(araddr_i);
    assign readShift  = araddr_i == pwconvPkg::ShiftAddr;
    assign readWord   = wordIndex(araddr_i);

    always_ff @(posedge clock_i or negedge arstN_i) begin
        if (!arstN_i) begin
            writeAccept <= 1'b0;
            bvalid_o    <= 1'b0;
            bresp_o     <= pwconvPkg::RespOkay;
            weights_o   <= '0;
            shift_o     <= '0;
        end else begin
            writeAccept <= awvalid_i && wvalid_i && !writeAccept && !bvalid_o;
            if (bvalid_o && bready_i) begin
                bvalid_o <= 1'b0;
            end
            if (writeFire) begin
                bvalid_o <= 1'b1;
                bresp_o  <= (writeWeight || writeShift) ? pwconvPkg::RespOkay
                                                        : pwconvPkg::RespSlvErr;
                if (writeShift && wstrb_i[0]) begin
                    shift_o <= wdata_i[pwconvPkg::ShiftWidth-1:0];
                end
                for (int o = 0; o < pwconvPkg::OutChannels; o++) begin
                    for (int g = 0; g < pwconvPkg::WordsPerChannel; g++) begin
                        if (writeWeight && writeWord == o*pwconvPkg::WordsPerChannel + g) begin
                            for (int k = 0; k < pwconvPkg::WeightsPerWord; k++) begin
                                if (wstrb_i[k]) begin
                                    weights_o[o][g*pwconvPkg::WeightsPerWord + k] <=
                                        wdata_i[k*pwconvPkg::WeightWidth +: pwconvPkg::WeightWidth];
                                end
                            end
                        end
                    end
                end
            end
        end
    end

    // unmapped addresses read as zero.
    always_comb begin
        readValue = '0;
        if (readShift) begin
            readValue = pwconvPkg::AxiDataWidth'(shift_o);
        end
        for (int o = 0; o < pwconvPkg::OutChannels; o++) begin
            for (int g = 0; g < pwconvPkg::WordsPerChannel; g++) begin
                if (readWeight && readWord == o*pwconvPkg::WordsPerChannel + g) begin
                    readValue = weights_o[o][g*pwconvPkg::WeightsPerWord +: pwconvPkg::WeightsPerWord];
                end
            end
        end
    end

    always_ff @(posedge clock_i or negedge arstN_i) begin
        if (!arstN_i) begin
            readAccept <= 1'b0;
            rvalid_o   <= 1'b0;
            rresp_o    <= pwconvPkg::RespOkay;
        end else begin
            readAccept <= arvalid_i && !readAccept && !rvalid_o;
            if (rvalid_o && rready_i) begin
                rvalid_o <= 1'b0;
            end
            if (readFire) begin
                rvalid_o <= 1'b1;
                rresp_o  <= (readWeight || readShift) ? pwconvPkg::RespOkay
                                                      : pwconvPkg::RespSlvErr;
            end
        end
    end

    always_ff @(posedge clock_i) begin
        if (readFire) begin
            rdata_o <= readValue;
        end
    end

    bHoldUntilReady : assert property (@(posedge clock_i) disable iff (!arstN_i)
        bvalid_o && !bready_i |=> bvalid_o && $stable(bresp_o));

    rHoldUntilReady : assert property (@(posedge clock_i) disable iff (!arstN_i)
        rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o) && $stable(rresp_o));

endmodule : convConfigRegs

//--- verilog/dspCascade.sv
`timescale 1ns/10ps

module dspCascade (
    input  bit                                       clock_i,
    input  bit                                       arstN_i,
    input  bit                                       enable_i,

    input  pwconvPkg::activationVec_t                activations_i,
    input  pwconvPkg::channelWeights_t               weights_i,
    input  bit [pwconvPkg::ShiftWidth-1:0]           shift_i,

    output bit signed [pwconvPkg::ActivationWidth-1:0] result_o
);

    bit signed [pwconvPkg::ProductWidth-1:0] products [pwconvPkg::InChannels];
    bit signed [pwconvPkg::AccWidth-1:0]     columnSumNext [pwconvPkg::Columns];

    // columnPipe[s] is the cascade stage s, where entry 0 holds the running sum.
    // Entries above s carry the column sums that are not yet added.
    bit signed [pwconvPkg::AccWidth-1:0] columnPipe [pwconvPkg::Columns][pwconvPkg::Columns];

    bit signed [pwconvPkg::AccWidth-1:0]        shifted;
    bit signed [pwconvPkg::ActivationWidth-1:0] saturated;

    always_ff @(posedge clock_i) begin
        if (enable_i) begin
            for (int i = 0; i < pwconvPkg::InChannels; i++) begin
                products[i] <= $signed(activations_i[i]) * $signed(weights_i[i]);
            end
        end
    end

    always_comb begin
        for (int c = 0; c < pwconvPkg::Columns; c++) begin
            columnSumNext[c] = '0;
            for (int k = 0; k < pwconvPkg::ColumnLength; k++) begin
                columnSumNext[c] = columnSumNext[c] + products[c*pwconvPkg::ColumnLength + k];
            end
        end
    end

    always_ff @(posedge clock_i) begin
        if (enable_i) begin
            for (int c = 0; c < pwconvPkg::Columns; c++) begin
                columnPipe[0][c] <= columnSumNext[c];
            end
            for (int s = 1; s < pwconvPkg::Columns; s++) begin
                columnPipe[s][0] <= columnPipe[s-1][0] + columnPipe[s-1][s];
                for (int k = s + 1; k < pwconvPkg::Columns; k++) begin
                    columnPipe[s][k] <= columnPipe[s-1][k]; // waits for its own stage.
                end
            end
        end
    end

    assign shifted = columnPipe[pwconvPkg::Columns-1][0] >>> shift_i;

    always_comb begin
        if (shifted > pwconvPkg::ResultMax) begin
            saturated = pwconvPkg::ActivationWidth'(pwconvPkg::ResultMax);
        end else if (shifted < pwconvPkg::ResultMin) begin
            saturated = pwconvPkg::ActivationWidth'(pwconvPkg::ResultMin);
        end else begin
            saturated = shifted[pwconvPkg::ActivationWidth-1:0];
        end
    end

    always_ff @(posedge clock_i or negedge arstN_i) begin
        if (!arstN_i) begin
            result_o <= '0;
        end else if (enable_i) begin
            result_o <= saturated;
        end
    end

endmodule : dspCascade

//--- verilog/pointwiseConvolve.sv
`timescale 1ns/10ps

module pointwiseConvolve (
    input  bit                             clock_i,
    input  bit                             arstN_i,

    input  bit                             slaveValid_i,
    output bit                             slaveReady_o,
    input  pwconvPkg::activationVec_t      slaveData_i,

    output bit                             masterValid_o,
    input  bit                             masterReady_i,
    output pwconvPkg::resultVec_t          masterData_o,

    input  pwconvPkg::weightMatrix_t       weights_i,
    input  bit [pwconvPkg::ShiftWidth-1:0] shift_i
);

    bit                                      inValid;
    pwconvPkg::activationVec_t               inData;
    bit                                      pipeEnable;
    bit [pwconvPkg::CascadeLatency-1:0]      validPipe;
    pwconvPkg::resultVec_t                   results;

    streamSkid #(
        .payload_t(pwconvPkg::activationVec_t)
    ) inSkid (
        .clock_i(clock_i),
        .arstN_i(arstN_i),

        .valid_i(slaveValid_i),
        .ready_o(slaveReady_o),
        .data_i (slaveData_i),

        .valid_o(inValid),
        .ready_i(pipeEnable),
        .data_o (inData)
    );

    // all channels see the same activations and move in lock step.
    for (genvar o = 0; o < pwconvPkg::OutChannels; o++) begin : channel
        dspCascade cascade (
            .clock_i      (clock_i),
            .arstN_i      (arstN_i),
            .enable_i     (pipeEnable),

            .activations_i(inData),
            .weights_i    (weights_i[o]),
            .shift_i      (shift_i),

            .result_o     (results[o])
        );
    end

    // the valid bits track the cascade registers stage by stage.
    always_ff @(posedge clock_i or negedge arstN_i) begin
        if (!arstN_i) begin
            validPipe <= '0;
        end else if (pipeEnable) begin
            validPipe <= {validPipe[pwconvPkg::CascadeLatency-2:0], inValid};
        end
    end

    // its registered ready stalls the whole pipeline when the output backs up.
    streamSkid #(
        .payload_t(pwconvPkg::resultVec_t)
    ) outSkid (
        .clock_i(clock_i),
        .arstN_i(arstN_i),

        .valid_i(validPipe[pwconvPkg::CascadeLatency-1]),
        .ready_o(pipeEnable),
        .data_i (results),

        .valid_o(masterValid_o),
        .ready_i(masterReady_i),
        .data_o (masterData_o)
    );

endmodule : pointwiseConvolve

//--- verilog/pwconvPkg.sv
package pwconvPkg;

    localparam int InChannels = 8;
    localparam int OutChannels = 4;
    localparam int ActivationWidth = 8;
    localparam int WeightWidth = 8;
    localparam int ProductWidth = ActivationWidth + WeightWidth;

    localparam int ColumnLength = 4; // multiply-add stages in one DSP column.
    localparam int Columns = InChannels / ColumnLength;
    localparam int AccWidth = 20;
    localparam int ShiftWidth = 5;

    // product, column sum, Columns-1 cascade adds and the requantize register.
    localparam int CascadeLatency = Columns + 2;

    localparam int ResultMax = (1 << (ActivationWidth - 1)) - 1;
    localparam int ResultMin = -(1 << (ActivationWidth - 1));

    localparam int AxiAddrWidth = 8;
    localparam int AxiDataWidth = 32;
    localparam int AxiStrbWidth = AxiDataWidth / 8;

    localparam int WeightsPerWord = AxiDataWidth / WeightWidth;
    localparam int WordsPerChannel = InChannels / WeightsPerWord;
    localparam int WeightWords = OutChannels * WordsPerChannel;

    localparam bit [AxiAddrWidth-1:0] WeightBase = 8'h00;
    localparam bit [AxiAddrWidth-1:0] ShiftAddr = 8'h20;

    localparam bit [1:0] RespOkay = 2'd0;
    localparam bit [1:0] RespSlvErr = 2'd2;

    typedef bit [InChannels-1:0][ActivationWidth-1:0] activationVec_t;
    typedef bit [OutChannels-1:0][ActivationWidth-1:0] resultVec_t;
    typedef bit [InChannels-1:0][WeightWidth-1:0] channelWeights_t;
    typedef bit [OutChannels-1:0][InChannels-1:0][WeightWidth-1:0] weightMatrix_t;

endpackage : pwconvPkg

//--- verilog/pwconvTop.sv
`timescale 1ns/10ps

module pwconvTop (
    input  bit                               clock_i,
    input  bit                               arstN_i,

    input  bit [pwconvPkg::AxiAddrWidth-1:0] awaddr_i,
    input  bit                               awvalid_i,
    output bit                               awready_o,
    input  bit [pwconvPkg::AxiDataWidth-1:0] wdata_i,
    input  bit [pwconvPkg::AxiStrbWidth-1:0] wstrb_i,
    input  bit                               wvalid_i,
    output bit                               wready_o,
    output bit [1:0]                         bresp_o,
    output bit                               bvalid_o,
    input  bit                               bready_i,
    input  bit [pwconvPkg::AxiAddrWidth-1:0] araddr_i,
    input  bit                               arvalid_i,
    output bit                               arready_o,
    output bit [pwconvPkg::AxiDataWidth-1:0] rdata_o,
    output bit [1:0]                         rresp_o,
    output bit                               rvalid_o,
    input  bit                               rready_i,

    input  bit                               slaveValid_i,
    output bit                               slaveReady_o,
    input  pwconvPkg::activationVec_t        slaveData_i,

    output bit                               masterValid_o,
    input  bit                               masterReady_i,
    output pwconvPkg::resultVec_t            masterData_o
);

    pwconvPkg::weightMatrix_t       weights;
    bit [pwconvPkg::ShiftWidth-1:0] shift;

    convConfigRegs configRegs (
        .clock_i  (clock_i),
        .arstN_i  (arstN_i),
        .awaddr_i (awaddr_i),
        .awvalid_i(awvalid_i),
        .awready_o(awready_o),
        .wdata_i  (wdata_i),
        .wstrb_i  (wstrb_i),
        .wvalid_i (wvalid_i),
        .wready_o (wready_o),
        .bresp_o  (bresp_o),
        .bvalid_o (bvalid_o),
        .bready_i (bready_i),
        .araddr_i (araddr_i),
        .arvalid_i(arvalid_i),
        .arready_o(arready_o),
        .rdata_o  (rdata_o),
        .rresp_o  (rresp_o),
        .rvalid_o (rvalid_o),
        .rready_i (rready_i),
        .weights_o(weights),
        .shift_o  (shift)
    );

    pointwiseConvolve convolve (
        .clock_i      (clock_i),
        .arstN_i      (arstN_i),
        .slaveValid_i (slaveValid_i),
        .slaveReady_o (slaveReady_o),
        .slaveData_i  (slaveData_i),
        .masterValid_o(masterValid_o),
        .masterReady_i(masterReady_i),
        .masterData_o (masterData_o),
        .weights_i    (weights),
        .shift_i      (shift)
    );

endmodule : pwconvTop

//--- verilog/streamSkid.sv
`timescale 1ns/10ps

module streamSkid #(
    parameter type payload_t = bit
) (
    input  bit       clock_i,
    input  bit       arstN_i,

    input  bit       valid_i,
    output bit       ready_o,
    input  payload_t data_i,

    output bit       valid_o,
    input  bit       ready_i,
    output payload_t data_o
);

    bit [1:0] count;
    bit [1:0] countNext;
    bit       readyReg;
    bit       push;
    bit       pop;
    payload_t mainData;
    payload_t spareData;

    assign ready_o = readyReg;
    assign valid_o = count != 2'd0;
    assign data_o  = mainData; // the head entry is always in mainData.
    assign push    = valid_i && readyReg;
    assign pop     = valid_o && ready_i;

    always_comb begin
        countNext = count;
        if (push && !pop) begin
            countNext = count + 2'd1;
        end else if (pop && !push) begin
            countNext = count - 2'd1;
        end
    end

    always_ff @(posedge clock_i or negedge arstN_i) begin
        if (!arstN_i) begin
            count    <= 2'd0;
            readyReg <= 1'b0;
        end else begin
            count    <= countNext;
            readyReg <= countNext != 2'd2; // ready looks at the next fill level.
        end
    end

    always_ff @(posedge clock_i) begin
        if (push) begin
            if (count == 2'd0 || pop) begin
                mainData <= data_i;
            end else begin
                spareData <= data_i; // downstream stalled with one entry held.
            end
        end else if (pop && count == 2'd2) begin
            mainData <= spareData;
        end
    end

    holdWhileStalled : assert property (@(posedge clock_i) disable iff (!arstN_i)
        valid_o && !ready_i |=> valid_o && $stable(data_o));

    noAcceptWhenFull : assert property (@(posedge clock_i) disable iff (!arstN_i)
        valid_i && ready_o |-> count != 2'd2);

endmodule : streamSkid
